// File: hw/id_settings.svh
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

`default_nettype none

// data and address word width
`define ID_XLEN 32

// register index width, 32 architectural registers
`define ID_REG_AW 5

`define ID_RESET_PC 32'h0000_0000

`default_nettype wire

`endif

// File: hw/id_pkg.sv
`include "id_settings.svh"
`default_nettype none

package id_pkg;

	typedef logic [`ID_XLEN-1:0] word_t;
	typedef logic [`ID_REG_AW-1:0] reg_addr_t;

	typedef enum logic [6:0] {
		OP_NOP    = 7'b0000000,
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_OP_IMM = 7'b0010011,
		OP_OP     = 7'b0110011
	} opcode_e;

	// execute class, six values need three bits
	typedef enum logic [2:0] {
		ALU_NOP, ALU_LOG, ALU_ARI, ALU_SHI, ALU_JAB, ALU_LAS
	} alusel_e;

	typedef struct packed {
		logic [6:0] funct7;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		reg_addr_t  rd;
		logic [6:0] opcode;
	} r_view_t;

	typedef struct packed {
		logic [11:0] imm12;
		reg_addr_t   rs1;
		logic [2:0]  funct3;
		reg_addr_t   rd;
		logic [6:0]  opcode;
	} i_view_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} sb_view_t;

	typedef struct packed {
		logic [19:0] imm20;
		reg_addr_t   rd;
		logic [6:0]  opcode;
	} uj_view_t;

	// one instruction word, four field layouts
	typedef union packed {
		r_view_t  r;
		i_view_t  i;
		sb_view_t sb;
		uj_view_t uj;
	} rv_inst_u;

endpackage

`default_nettype wire

// File: hw/inst_decoder.sv
`include "id_settings.svh"
`default_nettype none

module inst_decoder (
	input  id_pkg::word_t            pc_i,
	input  id_pkg::word_t            inst_i,
	output logic [1:0]               read_req_o,
	output id_pkg::reg_addr_t [1:0]  read_addr_o,
	output id_pkg::word_t            imm_o,
	output id_pkg::alusel_e          alusel_o,
	output id_pkg::opcode_e          opcode_o,
	output logic [2:0]               func3_o,
	output logic [6:0]               func7_o,
	output id_pkg::reg_addr_t        wd_o,
	output logic                     wreg_o,
	output logic                     valid_o,
	output id_pkg::word_t            br_offset_o,
	output id_pkg::word_t            jal_offset_o
);
	import id_pkg::*;

	localparam logic [6:0] F7_ALT = 7'b0100000; // sub / sra

	rv_inst_u inst;
	word_t    i_imm;
	word_t    s_imm;
	word_t    u_imm;

	assign inst  = inst_i;
	assign i_imm = {{(`ID_XLEN-12){inst.i.imm12[11]}}, inst.i.imm12};
	assign s_imm = {{(`ID_XLEN-12){inst.sb.imm_hi[6]}}, inst.sb.imm_hi, inst.sb.imm_lo};
	assign u_imm = {inst.uj.imm20, 12'b0};

	// B and J offsets, bit 0 always zero
	assign br_offset_o = {{(`ID_XLEN-12){inst.sb.imm_hi[6]}}, inst.sb.imm_lo[0],
		inst.sb.imm_hi[5:0], inst.sb.imm_lo[4:1], 1'b0};
	assign jal_offset_o = {{(`ID_XLEN-20){inst.uj.imm20[19]}}, inst.uj.imm20[7:0],
		inst.uj.imm20[8], inst.uj.imm20[18:9], 1'b0};

	always_comb begin
		case (inst.r.opcode)
			OP_LUI, OP_AUIPC, OP_JAL: valid_o = 1'b1;
			OP_JALR:   valid_o = (inst.i.funct3 == 3'b000);
			OP_BRANCH: valid_o = (inst.sb.funct3[2:1] != 2'b01);
			OP_LOAD:   valid_o = (inst.i.funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
			OP_STORE:  valid_o = (inst.sb.funct3 inside {3'b000, 3'b001, 3'b010});
			OP_OP_IMM: begin
				case (inst.r.funct3)
					3'b001:  valid_o = (inst.r.funct7 == 7'b0);
					3'b101:  valid_o = (inst.r.funct7 == 7'b0) || (inst.r.funct7 == F7_ALT);
					default: valid_o = 1'b1;
				endcase
			end
			OP_OP: valid_o = (inst.r.funct7 == 7'b0) ||
				(inst.r.funct7 == F7_ALT && inst.r.funct3 inside {3'b000, 3'b101});
			default: valid_o = 1'b0; // fence and anything else
		endcase
	end

	always_comb begin
		read_req_o     = 2'b00;
		read_addr_o[0] = inst.r.rs1;
		read_addr_o[1] = inst.r.rs2;
		imm_o          = '0;
		alusel_o       = ALU_NOP;
		opcode_o       = OP_NOP;
		func3_o        = 3'b000;
		func7_o        = 7'b0;
		wreg_o         = 1'b0;
		if (valid_o) begin
			opcode_o = opcode_e'(inst.r.opcode);
			func3_o  = inst.r.funct3;
			case (inst.r.opcode)
				OP_LUI, OP_AUIPC: begin
					alusel_o = ALU_LOG;
					wreg_o   = 1'b1;
					func3_o  = 3'b000;
					imm_o    = (inst.r.opcode == OP_AUIPC) ? u_imm + pc_i : u_imm;
				end
				OP_JAL: begin
					alusel_o = ALU_JAB;
					wreg_o   = 1'b1;
					func3_o  = 3'b000;
				end
				OP_JALR: begin
					alusel_o   = ALU_JAB;
					wreg_o     = 1'b1;
					read_req_o = 2'b01;
					imm_o      = i_imm; // lands on op2, target adds it to rs1
				end
				OP_BRANCH: begin
					alusel_o   = ALU_JAB;
					read_req_o = 2'b11;
				end
				OP_LOAD, OP_STORE: begin
					alusel_o   = ALU_LAS;
					wreg_o     = (inst.r.opcode == OP_LOAD);
					read_req_o = wreg_o ? 2'b01 : 2'b11;
					imm_o      = wreg_o ? i_imm : s_imm;
				end
				OP_OP_IMM, OP_OP: begin
					wreg_o     = 1'b1;
					read_req_o = (inst.r.opcode == OP_OP) ? 2'b11 : 2'b01;
					imm_o      = (inst.r.opcode == OP_OP) ? '0 : i_imm;
					case (inst.r.funct3)
						3'b000, 3'b010, 3'b011: alusel_o = ALU_ARI;
						3'b001, 3'b101: begin
							alusel_o = ALU_SHI;
							func7_o  = inst.r.funct7;
							if (inst.r.opcode == OP_OP_IMM)
								imm_o = word_t'(inst.r.rs2); // shamt, zero extended
						end
						default: alusel_o = ALU_LOG;
					endcase
					if (inst.r.opcode == OP_OP)
						func7_o = inst.r.funct7;
				end
				default: ;
			endcase
		end
		wd_o = wreg_o ? inst.r.rd : '0;
	end

endmodule

`default_nettype wire

// File: hw/operand_forward.sv
`default_nettype none

module operand_forward (
	input  logic              read_req_i,
	input  id_pkg::reg_addr_t read_addr_i,
	input  id_pkg::word_t     imm_i,
	input  id_pkg::word_t     reg_data_i,
	input  logic              ex_wreg_i,
	input  id_pkg::reg_addr_t ex_wd_i,
	input  logic              ex_is_load_i,
	input  id_pkg::word_t     ex_wdata_i,
	input  logic              mem_wreg_i,
	input  id_pkg::reg_addr_t mem_wd_i,
	input  id_pkg::word_t     mem_wdata_i,
	output id_pkg::word_t     operand_o,
	output logic              stall_o
);
	logic ex_hit;
	logic mem_hit;

	// x0 not special cased
	assign ex_hit  = ex_wreg_i && (ex_wd_i == read_addr_i);
	assign mem_hit = mem_wreg_i && (mem_wd_i == read_addr_i);

	always_comb begin
		stall_o = 1'b0;
		if (!read_req_i) begin
			operand_o = imm_i;
		end else if (ex_hit) begin
			// load data not there yet
			stall_o   = ex_is_load_i;
			operand_o = ex_wdata_i;
		end else if (mem_hit) begin
			operand_o = mem_wdata_i;
		end else begin
			operand_o = reg_data_i;
		end
	end

endmodule

`default_nettype wire

// File: hw/branch_resolver.sv
`include "id_settings.svh"
`default_nettype none

module branch_resolver (
	input  id_pkg::word_t   pc_i,
	input  id_pkg::opcode_e opcode_i,
	input  logic [2:0]      func3_i,
	input  id_pkg::word_t   op1_i,
	input  id_pkg::word_t   op2_i,
	input  logic [1:0]      stall_req_i,
	input  logic            flush_i,
	input  id_pkg::word_t   br_offset_i,
	input  id_pkg::word_t   jal_offset_i,
	output logic            stall_o,
	output logic            branch_flag_o,
	output id_pkg::word_t   branch_target_o,
	output id_pkg::word_t   link_addr_o
);
	import id_pkg::*;

	logic taken;

	assign stall_o     = |stall_req_i;
	assign link_addr_o = pc_i + `ID_XLEN'(4);

	always_comb begin
		taken           = 1'b0;
		branch_target_o = pc_i + br_offset_i;
		case (opcode_i)
			OP_JAL: begin
				taken           = 1'b1;
				branch_target_o = pc_i + jal_offset_i;
			end
			OP_JALR: begin
				taken           = 1'b1;
				branch_target_o = (op1_i + op2_i) & ~word_t'(1);
			end
			OP_BRANCH: begin
				case (func3_i)
					3'b000:  taken = (op1_i == op2_i);
					3'b001:  taken = (op1_i != op2_i);
					3'b100:  taken = ($signed(op1_i) < $signed(op2_i));
					3'b101:  taken = ($signed(op1_i) >= $signed(op2_i));
					3'b110:  taken = (op1_i < op2_i);
					3'b111:  taken = (op1_i >= op2_i);
					default: taken = 1'b0;
				endcase
			end
			default: ;
		endcase
	end

	// wrong-path or stalled instructions never redirect
	assign branch_flag_o = taken && !stall_o && !flush_i;

endmodule

`default_nettype wire

// File: hw/id_ex_reg.sv
`include "id_settings.svh"
`default_nettype none

module id_ex_reg (
	input  logic              clk,
	input  logic              reset_i,
	input  logic              valid_i,
	input  id_pkg::alusel_e   alusel_i,
	input  id_pkg::opcode_e   opcode_i,
	input  logic [2:0]        func3_i,
	input  logic [6:0]        func7_i,
	input  id_pkg::reg_addr_t wd_i,
	input  logic              wreg_i,
	input  id_pkg::word_t     reg1_i,
	input  id_pkg::word_t     reg2_i,
	input  id_pkg::word_t     link_addr_i,
	input  logic              branch_taken_i,
	input  logic              stall_i,
	output logic              ex_valid_o,
	output id_pkg::alusel_e   ex_alusel_o,
	output id_pkg::opcode_e   ex_opcode_o,
	output logic [2:0]        ex_func3_o,
	output logic [6:0]        ex_func7_o,
	output id_pkg::reg_addr_t ex_wd_o,
	output logic              ex_wreg_o,
	output id_pkg::word_t     ex_reg1_o,
	output id_pkg::word_t     ex_reg2_o,
	output id_pkg::word_t     ex_link_addr_o,
	output logic              ex_is_load_o,
	output logic              flush_o
);
	import id_pkg::*;

	logic taken_q; // ex holds a taken branch or jump
	logic bubble;

	assign flush_o      = taken_q;
	assign bubble       = stall_i || taken_q;
	assign ex_is_load_o = (ex_opcode_o == OP_LOAD);

	always_ff @(posedge clk) begin
		if (reset_i || bubble) begin
			ex_valid_o  <= 1'b0;
			ex_alusel_o <= ALU_NOP;
			ex_opcode_o <= OP_NOP;
			ex_func3_o  <= 3'b000;
			ex_func7_o  <= 7'b0;
			ex_wd_o     <= '0;
			ex_wreg_o   <= 1'b0;
			taken_q     <= 1'b0;
		end else begin
			ex_valid_o  <= valid_i;
			ex_alusel_o <= alusel_i;
			ex_opcode_o <= opcode_i;
			ex_func3_o  <= func3_i;
			ex_func7_o  <= func7_i;
			ex_wd_o     <= wd_i;
			ex_wreg_o   <= wreg_i;
			taken_q     <= branch_taken_i;
		end
	end

	always_ff @(posedge clk) begin
		ex_reg1_o <= reg1_i;
		ex_reg2_o <= reg2_i;
	end

	always_ff @(posedge clk) begin
		if (reset_i)
			ex_link_addr_o <= `ID_RESET_PC;
		else
			ex_link_addr_o <= link_addr_i;
	end

endmodule

`default_nettype wire

// File: hw/id_stage.sv
`default_nettype none

module id_stage (
	input  logic              clk,
	input  logic              reset_i,
	input  id_pkg::word_t     pc_i,
	input  id_pkg::word_t     inst_i,
	input  id_pkg::word_t     reg1_data_i,
	input  id_pkg::word_t     reg2_data_i,
	input  id_pkg::word_t     ex_wdata_i,
	input  id_pkg::word_t     mem_wdata_i,
	input  logic              mem_wreg_i,
	input  id_pkg::reg_addr_t mem_wd_i,
	output logic              reg1_read_o,
	output logic              reg2_read_o,
	output id_pkg::reg_addr_t reg1_addr_o,
	output id_pkg::reg_addr_t reg2_addr_o,
	output logic              ex_valid_o,
	output id_pkg::alusel_e   ex_alusel_o,
	output id_pkg::opcode_e   ex_opcode_o,
	output logic [2:0]        ex_func3_o,
	output logic [6:0]        ex_func7_o,
	output id_pkg::word_t     ex_reg1_o,
	output id_pkg::word_t     ex_reg2_o,
	output id_pkg::reg_addr_t ex_wd_o,
	output logic              ex_wreg_o,
	output id_pkg::word_t     ex_link_addr_o,
	output logic              branch_flag_o,
	output id_pkg::word_t     branch_target_o,
	output logic              stall_o
);
	import id_pkg::*;

	logic [1:0]      read_req;
	reg_addr_t [1:0] read_addr;
	word_t [1:0]     reg_data;
	word_t [1:0]     operand;
	logic [1:0]      stall_req;
	word_t           imm;
	word_t           br_offset;
	word_t           jal_offset;
	word_t           link_addr;
	alusel_e         alusel;
	opcode_e         opcode;
	logic [2:0]      func3;
	logic [6:0]      func7;
	reg_addr_t       wd;
	logic            wreg;
	logic            valid;
	logic            ex_is_load;
	logic            flush;

	assign reg1_read_o = read_req[0];
	assign reg2_read_o = read_req[1];
	assign reg1_addr_o = read_addr[0];
	assign reg2_addr_o = read_addr[1];
	assign reg_data    = {reg2_data_i, reg1_data_i};

	inst_decoder u_decoder (
		.pc_i(pc_i), .inst_i(inst_i),
		.read_req_o(read_req), .read_addr_o(read_addr), .imm_o(imm),
		.alusel_o(alusel), .opcode_o(opcode), .func3_o(func3), .func7_o(func7),
		.wd_o(wd), .wreg_o(wreg), .valid_o(valid),
		.br_offset_o(br_offset), .jal_offset_o(jal_offset)
	);

	for (genvar i = 0; i < 2; i++) begin : g_fwd
		operand_forward u_fwd (
			.read_req_i(read_req[i]), .read_addr_i(read_addr[i]), .imm_i(imm),
			.reg_data_i(reg_data[i]),
			.ex_wreg_i(ex_wreg_o), .ex_wd_i(ex_wd_o), .ex_is_load_i(ex_is_load),
			.ex_wdata_i(ex_wdata_i),
			.mem_wreg_i(mem_wreg_i), .mem_wd_i(mem_wd_i), .mem_wdata_i(mem_wdata_i),
			.operand_o(operand[i]), .stall_o(stall_req[i])
		);
	end

	branch_resolver u_branch (
		.pc_i(pc_i), .opcode_i(opcode), .func3_i(func3),
		.op1_i(operand[0]), .op2_i(operand[1]),
		.stall_req_i(stall_req), .flush_i(flush),
		.br_offset_i(br_offset), .jal_offset_i(jal_offset),
		.stall_o(stall_o), .branch_flag_o(branch_flag_o),
		.branch_target_o(branch_target_o), .link_addr_o(link_addr)
	);

	id_ex_reg u_id_ex (
		.clk(clk), .reset_i(reset_i),
		.valid_i(valid), .alusel_i(alusel), .opcode_i(opcode),
		.func3_i(func3), .func7_i(func7), .wd_i(wd), .wreg_i(wreg),
		.reg1_i(operand[0]), .reg2_i(operand[1]), .link_addr_i(link_addr),
		.branch_taken_i(branch_flag_o), .stall_i(stall_o),
		.ex_valid_o(ex_valid_o), .ex_alusel_o(ex_alusel_o), .ex_opcode_o(ex_opcode_o),
		.ex_func3_o(ex_func3_o), .ex_func7_o(ex_func7_o), .ex_wd_o(ex_wd_o),
		.ex_wreg_o(ex_wreg_o), .ex_reg1_o(ex_reg1_o), .ex_reg2_o(ex_reg2_o),
		.ex_link_addr_o(ex_link_addr_o), .ex_is_load_o(ex_is_load), .flush_o(flush)
	);

endmodule

`default_nettype wire

// File: sim/id_stage_checker.sv
`default_nettype none

module id_stage_checker (
	input logic       clk,
	input logic       reset_i,
	input logic       stall_o,
	input logic       branch_flag_o,
	input logic       ex_valid_o,
	input logic       ex_wreg_o,
	input logic [6:0] ex_opcode_o,
	input logic [2:0] ex_alusel_o
);
	timeunit 1ns;
	timeprecision 100ps;

	// load has left ex after one bubble
	single_cycle_stall: assert property (@(posedge clk) disable iff (reset_i)
		stall_o |=> !stall_o)
		else $error("stall_o high for more than one cycle");

	bubble_after_stall: assert property (@(posedge clk) disable iff (reset_i)
		stall_o |=> !ex_valid_o)
		else $error("ex_valid_o high after a stall");

	// branch itself enters ex first, the one behind it is flushed
	bubble_after_branch: assert property (@(posedge clk) disable iff (reset_i)
		branch_flag_o |-> ##2 !ex_valid_o)
		else $error("ex_valid_o high for the instruction after a taken branch");

	reset_state: assert property (@(posedge clk)
		reset_i |=> (!ex_valid_o && !ex_wreg_o && ex_opcode_o == 7'b0 &&
			ex_alusel_o == 3'b0 && !stall_o && !branch_flag_o))
		else $error("control outputs not cleared by reset");

endmodule

`default_nettype wire

// File: sim/id_stage_tb.sv
`default_nettype none

module id_stage_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import id_pkg::*;

	typedef struct packed {
		word_t      pc;
		word_t      inst;
		word_t      r1;
		word_t      r2;
		logic       mwreg;
		reg_addr_t  mwd;
		word_t      mwdata;
		word_t      exw;
		logic       stall;
		logic       br;
		word_t      tgt;
		logic       valid;
		logic [2:0] alusel;
		logic [2:0] f3;
		logic [6:0] f7;
		reg_addr_t  wd;
		logic       wreg;
		word_t      xr1;
		word_t      xr2;
	} entry_t;

	logic      clk;
	logic      reset_i;
	word_t     pc_i;
	word_t     inst_i;
	word_t     reg1_data_i;
	word_t     reg2_data_i;
	word_t     ex_wdata_i;
	word_t     mem_wdata_i;
	logic      mem_wreg_i;
	reg_addr_t mem_wd_i;
	logic      reg1_read_o;
	logic      reg2_read_o;
	reg_addr_t reg1_addr_o;
	reg_addr_t reg2_addr_o;
	logic      ex_valid_o;
	alusel_e   ex_alusel_o;
	opcode_e   ex_opcode_o;
	logic [2:0] ex_func3_o;
	logic [6:0] ex_func7_o;
	word_t     ex_reg1_o;
	word_t     ex_reg2_o;
	reg_addr_t ex_wd_o;
	logic      ex_wreg_o;
	word_t     ex_link_addr_o;
	logic      branch_flag_o;
	word_t     branch_target_o;
	logic      stall_o;

	entry_t tbl[$];
	entry_t cur;
	entry_t e;
	word_t  next_pc;

	id_stage u_dut (.*);

	bind id_stage id_stage_checker u_checker (
		.clk(clk), .reset_i(reset_i), .stall_o(stall_o), .branch_flag_o(branch_flag_o),
		.ex_valid_o(ex_valid_o), .ex_wreg_o(ex_wreg_o), .ex_opcode_o(ex_opcode_o),
		.ex_alusel_o(ex_alusel_o)
	);

	always #5 clk = ~clk;

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got=%h expected=%h (pc %h)", name, got, exp, e.pc);
			$display("TEST FAIL");
			$fatal(1);
		end
	endtask

	function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
		input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd);
		rv_inst_u u;
		u = '0;
		u.r.funct7 = f7;
		u.r.rs2    = rs2;
		u.r.rs1    = rs1;
		u.r.funct3 = f3;
		u.r.rd     = rd;
		u.r.opcode = OP_OP;
		return u;
	endfunction

	function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
		input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] op);
		rv_inst_u u;
		u = '0;
		u.i.imm12  = imm;
		u.i.rs1    = rs1;
		u.i.funct3 = f3;
		u.i.rd     = rd;
		u.i.opcode = op;
		return u;
	endfunction

	// store when b is low, branch when high
	function automatic word_t enc_sb(input logic b, input word_t off, input reg_addr_t rs2,
		input reg_addr_t rs1, input logic [2:0] f3);
		rv_inst_u u;
		u = '0;
		u.sb.rs2    = rs2;
		u.sb.rs1    = rs1;
		u.sb.funct3 = f3;
		if (b) begin
			u.sb.imm_hi = {off[12], off[10:5]};
			u.sb.imm_lo = {off[4:1], off[11]};
			u.sb.opcode = OP_BRANCH;
		end else begin
			u.sb.imm_hi = off[11:5];
			u.sb.imm_lo = off[4:0];
			u.sb.opcode = OP_STORE;
		end
		return u;
	endfunction

	function automatic word_t enc_uj(input logic [19:0] imm, input reg_addr_t rd,
		input logic [6:0] op);
		rv_inst_u u;
		u = '0;
		u.uj.imm20  = imm;
		u.uj.rd     = rd;
		u.uj.opcode = op;
		return u;
	endfunction

	function automatic logic [19:0] j_bits(input word_t off);
		return {off[20], off[10:1], off[11], off[19:12]};
	endfunction

	// register fields each format carries, bit 0 rs1 and bit 1 rs2
	function automatic logic [1:0] reads_of(input word_t inst);
		case (inst[6:0])
			OP_OP, OP_BRANCH, OP_STORE:  return 2'b11;
			OP_OP_IMM, OP_LOAD, OP_JALR: return 2'b01;
			default:                     return 2'b00;
		endcase
	endfunction

	task automatic stim(input word_t inst, input word_t r1, input word_t r2);
		cur      = '0;
		cur.pc   = next_pc;
		next_pc  = next_pc + 32'd4;
		cur.inst = inst;
		cur.r1   = r1;
		cur.r2   = r2;
		cur.exw  = 32'hEEEE_EEEE;
	endtask

	task automatic taken_to(input word_t tgt);
		cur.br  = 1'b1;
		cur.tgt = tgt;
	endtask

	task automatic mem_fwd(input reg_addr_t wd, input word_t data);
		cur.mwreg  = 1'b1;
		cur.mwd    = wd;
		cur.mwdata = data;
	endtask

	task automatic expect_ex(input alusel_e a, input logic [2:0] f3, input logic [6:0] f7,
		input reg_addr_t wd, input logic wreg, input word_t x1, input word_t x2);
		cur.valid  = 1'b1;
		cur.alusel = a;
		cur.f3     = f3;
		cur.f7     = f7;
		cur.wd     = wd;
		cur.wreg   = wreg;
		cur.xr1    = x1;
		cur.xr2    = x2;
		tbl.push_back(cur);
	endtask

	task automatic expect_bubble();
		tbl.push_back(cur); // all control fields already zero
	endtask

	task automatic build_table();
		next_pc = 32'h100;
		stim(enc_i(12'hFFB, 2, 0, 1, OP_OP_IMM), 32'h10, 32'h22); // addi
		expect_ex(ALU_ARI, 0, 0, 1, 1, 32'h10, 32'hFFFF_FFFB);
		stim(enc_i(12'h7FF, 4, 2, 3, OP_OP_IMM), 32'h20, 32'h0); // slti
		expect_ex(ALU_ARI, 2, 0, 3, 1, 32'h20, 32'h7FF);
		stim(enc_i(12'h800, 6, 4, 5, OP_OP_IMM), 32'h30, 32'h0); // xori
		expect_ex(ALU_LOG, 4, 0, 5, 1, 32'h30, 32'hFFFF_F800);
		stim(enc_i(12'h003, 8, 1, 7, OP_OP_IMM), 32'h40, 32'h0); // slli
		expect_ex(ALU_SHI, 1, 0, 7, 1, 32'h40, 32'h3);
		stim(enc_i(12'h41F, 10, 5, 9, OP_OP_IMM), 32'h8000_0000, 32'h0); // srai
		expect_ex(ALU_SHI, 5, 7'h20, 9, 1, 32'h8000_0000, 32'h1F);
		stim(enc_r(7'h00, 13, 12, 0, 11), 32'h111, 32'h222); // add
		expect_ex(ALU_ARI, 0, 0, 11, 1, 32'h111, 32'h222);
		stim(enc_r(7'h20, 16, 15, 0, 14), 32'h333, 32'h444); // sub
		expect_ex(ALU_ARI, 0, 7'h20, 14, 1, 32'h333, 32'h444);
		stim(enc_r(7'h00, 19, 18, 2, 17), 32'h555, 32'h666); // slt
		expect_ex(ALU_ARI, 2, 0, 17, 1, 32'h555, 32'h666);
		stim(enc_r(7'h00, 22, 21, 7, 20), 32'h777, 32'h888); // and
		expect_ex(ALU_LOG, 7, 0, 20, 1, 32'h777, 32'h888);
		stim(enc_r(7'h00, 25, 24, 5, 23), 32'h999, 32'h4); // srl
		expect_ex(ALU_SHI, 5, 0, 23, 1, 32'h999, 32'h4);
		stim(enc_uj(20'h12345, 26, OP_LUI), 32'h1, 32'h2);
		expect_ex(ALU_LOG, 0, 0, 26, 1, 32'h1234_5000, 32'h1234_5000);
		stim(enc_uj(20'hFFFFF, 27, OP_AUIPC), 32'h1, 32'h2);
		expect_ex(ALU_LOG, 0, 0, 27, 1, 32'hFFFF_F000 + cur.pc, 32'hFFFF_F000 + cur.pc);
		stim(enc_i(12'h008, 29, 2, 28, OP_LOAD), 32'h2000, 32'h0); // lw
		expect_ex(ALU_LAS, 2, 0, 28, 1, 32'h2000, 32'h8);
		stim(enc_sb(0, 32'hFFFF_FFFC, 30, 31, 2), 32'h3000, 32'hABCD); // sw, data on op2
		expect_ex(ALU_LAS, 2, 0, 0, 0, 32'h3000, 32'hABCD);
		// branches, each taken one flushes the next entry
		stim(enc_sb(1, 32'h10, 2, 1, 0), 32'h5, 32'h5); // beq taken
		taken_to(cur.pc + 32'h10);
		expect_ex(ALU_JAB, 0, 0, 0, 0, 32'h5, 32'h5);
		stim(enc_sb(1, 32'h20, 2, 1, 1), 32'h1, 32'h2); // bne on wrong path
		expect_bubble();
		stim(enc_sb(1, 32'h20, 2, 1, 1), 32'h7, 32'h7); // bne not taken
		expect_ex(ALU_JAB, 1, 0, 0, 0, 32'h7, 32'h7);
		stim(enc_sb(1, 32'hFFFF_FFF8, 2, 1, 4), 32'hFFFF_FFFF, 32'h1); // blt taken
		taken_to(cur.pc - 32'h8);
		expect_ex(ALU_JAB, 4, 0, 0, 0, 32'hFFFF_FFFF, 32'h1);
		stim(enc_i(12'h001, 4, 0, 3, OP_OP_IMM), 32'h0, 32'h0);
		expect_bubble();
		stim(enc_sb(1, 32'h40, 2, 1, 5), 32'hFFFF_FFFF, 32'h1); // bge not taken
		expect_ex(ALU_JAB, 5, 0, 0, 0, 32'hFFFF_FFFF, 32'h1);
		stim(enc_sb(1, 32'h40, 2, 1, 6), 32'hFFFF_FFFF, 32'h1); // bltu not taken
		expect_ex(ALU_JAB, 6, 0, 0, 0, 32'hFFFF_FFFF, 32'h1);
		stim(enc_sb(1, 32'h100, 2, 1, 7), 32'hFFFF_FFFF, 32'h1); // bgeu taken
		taken_to(cur.pc + 32'h100);
		expect_ex(ALU_JAB, 7, 0, 0, 0, 32'hFFFF_FFFF, 32'h1);
		stim(enc_i(12'h001, 4, 0, 3, OP_OP_IMM), 32'h0, 32'h0);
		expect_bubble();
		stim(enc_sb(1, 32'h40, 2, 1, 0), 32'h3, 32'h4); // beq not taken
		expect_ex(ALU_JAB, 0, 0, 0, 0, 32'h3, 32'h4);
		stim(enc_sb(1, 32'h40, 2, 1, 4), 32'h5, 32'hFFFF_FFFE); // blt not taken
		expect_ex(ALU_JAB, 4, 0, 0, 0, 32'h5, 32'hFFFF_FFFE);
		stim(enc_sb(1, 32'hFFFF_FFE0, 2, 1, 5), 32'h5, 32'hFFFF_FFFE); // bge taken
		taken_to(cur.pc - 32'h20);
		expect_ex(ALU_JAB, 5, 0, 0, 0, 32'h5, 32'hFFFF_FFFE);
		stim(enc_i(12'h001, 4, 0, 3, OP_OP_IMM), 32'h0, 32'h0);
		expect_bubble();
		stim(enc_sb(1, 32'h4, 2, 1, 6), 32'h1, 32'hFFFF_FFFF); // bltu taken
		taken_to(cur.pc + 32'h4);
		expect_ex(ALU_JAB, 6, 0, 0, 0, 32'h1, 32'hFFFF_FFFF);
		stim(enc_i(12'h001, 4, 0, 3, OP_OP_IMM), 32'h0, 32'h0);
		expect_bubble();
		stim(enc_sb(1, 32'h40, 2, 1, 7), 32'h1, 32'h2); // bgeu not taken
		expect_ex(ALU_JAB, 7, 0, 0, 0, 32'h1, 32'h2);
		// jumps
		stim(enc_uj(j_bits(32'h800), 1, OP_JAL), 32'h0, 32'h0);
		taken_to(cur.pc + 32'h800);
		expect_ex(ALU_JAB, 0, 0, 1, 1, 32'h0, 32'h0);
		stim(enc_i(12'h001, 4, 0, 3, OP_OP_IMM), 32'h0, 32'h0);
		expect_bubble();
		stim(enc_i(12'hFFD, 6, 0, 5, OP_JALR), 32'h1000, 32'h0);
		taken_to(32'h0000_0FFC); // 0x1000 - 3, bit 0 cleared
		expect_ex(ALU_JAB, 0, 0, 5, 1, 32'h1000, 32'hFFFF_FFFD);
		stim(enc_i(12'h001, 4, 0, 3, OP_OP_IMM), 32'h0, 32'h0);
		expect_bubble();
		// forwarding
		stim(enc_i(12'h001, 8, 0, 7, OP_OP_IMM), 32'h11, 32'h0);
		expect_ex(ALU_ARI, 0, 0, 7, 1, 32'h11, 32'h1);
		stim(enc_r(7'h00, 10, 7, 0, 9), 32'h1234, 32'h22);
		cur.exw = 32'hCAFE_0001;
		expect_ex(ALU_ARI, 0, 0, 9, 1, 32'hCAFE_0001, 32'h22);
		stim(enc_r(7'h00, 13, 12, 0, 11), 32'h33, 32'h1234);
		mem_fwd(13, 32'hBEEF_0002);
		expect_ex(ALU_ARI, 0, 0, 11, 1, 32'h33, 32'hBEEF_0002);
		stim(enc_r(7'h00, 15, 11, 0, 14), 32'h1234, 32'h44);
		mem_fwd(11, 32'hBEEF_0003);
		cur.exw = 32'hCAFE_0003; // ex wins over mem
		expect_ex(ALU_ARI, 0, 0, 14, 1, 32'hCAFE_0003, 32'h44);
		// load-use
		stim(enc_i(12'h000, 17, 2, 16, OP_LOAD), 32'h4000, 32'h0);
		expect_ex(ALU_LAS, 2, 0, 16, 1, 32'h4000, 32'h0);
		stim(enc_r(7'h00, 19, 16, 0, 18), 32'h1111, 32'h19);
		mem_fwd(16, 32'hD00D_0004); // load result reaches mem after the bubble
		cur.exw   = 32'h5555_5555;
		cur.stall = 1'b1;
		expect_ex(ALU_ARI, 0, 0, 18, 1, 32'hD00D_0004, 32'h19);
		stim(32'h0000_000F, 32'h0, 32'h0); // fence, not decoded
		expect_bubble();
	endtask

	task automatic drive(input entry_t d);
		pc_i        = d.pc;
		inst_i      = d.inst;
		reg1_data_i = d.r1;
		reg2_data_i = d.r2;
		mem_wreg_i  = d.mwreg;
		mem_wd_i    = d.mwd;
		mem_wdata_i = d.mwdata;
		ex_wdata_i  = d.exw;
	endtask

	task automatic wait_release();
		int n;
		n = 0;
		while (stall_o) begin
			if (n == 20) begin
				$display("timeout: stall_o still high after 20 cycles");
				$display("TEST FAIL");
				$fatal(1);
			end
			@(posedge clk);
			#1;
			n++;
		end
	endtask

	task automatic check_reads(input entry_t d);
		logic [1:0] want;
		want = reads_of(d.inst);
		check("reg1_read_o", 32'(reg1_read_o), 32'(want[0]));
		check("reg2_read_o", 32'(reg2_read_o), 32'(want[1]));
		if (want[0])
			check("reg1_addr_o", 32'(reg1_addr_o), 32'(d.inst[19:15]));
		if (want[1])
			check("reg2_addr_o", 32'(reg2_addr_o), 32'(d.inst[24:20]));
	endtask

	task automatic check_ex(input entry_t d);
		check("ex_valid_o", 32'(ex_valid_o), 32'(d.valid));
		check("ex_opcode_o", 32'(ex_opcode_o), d.valid ? 32'(d.inst[6:0]) : 32'h0);
		check("ex_alusel_o", 32'(ex_alusel_o), 32'(d.alusel));
		check("ex_func3_o", 32'(ex_func3_o), 32'(d.f3));
		check("ex_func7_o", 32'(ex_func7_o), 32'(d.f7));
		check("ex_wd_o", 32'(ex_wd_o), 32'(d.wd));
		check("ex_wreg_o", 32'(ex_wreg_o), 32'(d.wreg));
		check("ex_link_addr_o", ex_link_addr_o, d.pc + 32'd4);
		if (d.valid) begin
			check("ex_reg1_o", ex_reg1_o, d.xr1);
			check("ex_reg2_o", ex_reg2_o, d.xr2);
		end
	endtask

	initial begin
		clk     = 1'b0;
		reset_i = 1'b1;
		e       = '0;
		drive('0);
		build_table();
		repeat (3) @(posedge clk);
		#1;
		reset_i = 1'b0;
		foreach (tbl[k]) begin
			e = tbl[k];
			drive(e);
			#4;
			check("stall_o", 32'(stall_o), 32'(e.stall));
			check_reads(e);
			if (e.stall) begin
				@(posedge clk);
				#1;
				check("ex_valid_o", 32'(ex_valid_o), 32'h0); // bubble during the stall
				check("ex_wreg_o", 32'(ex_wreg_o), 32'h0);
				wait_release();
			end
			check("branch_flag_o", 32'(branch_flag_o), 32'(e.br));
			if (e.br)
				check("branch_target_o", branch_target_o, e.tgt);
			@(posedge clk);
			#1;
			check_ex(e);
		end
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+hw
hw/id_pkg.sv
hw/inst_decoder.sv
hw/operand_forward.sv
hw/branch_resolver.sv
hw/id_ex_reg.sv
hw/id_stage.sv
sim/id_stage_checker.sv
sim/id_stage_tb.sv

// File: run.sh
#!/bin/sh
# build and run the decode-stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module id_stage_tb \
	-o id_stage_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/id_stage_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "TEST FAIL" sim.log; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
exit 0
